// File: hw/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    // instruction field layout
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG_W  = 7'b0111011;
    localparam logic [OPCODE_W-1:0] OP_IMM_W  = 7'b0011011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;

    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_DIV, ALU_REMU, ALU_REM,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_PC_PLUS4,  // link value for jal/jalr
        SRC_IMM_PC
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_kind_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD
    } mem_size_e;

    typedef struct packed {
        logic [INST_W-1:0]     inst;  // raw word for immediate generation
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        imm_kind_e             imm_kind;
        logic                  word_op;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic                  store;
        logic                  illegal;
        logic                  ebreak;
    } dec_word_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  word_op;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic                  store;
        logic                  illegal;
        logic                  ebreak;
        logic [XLEN-1:0]       imm;
        logic [7:0]            wmask;  // byte lanes for stores
    } exec_ctrl_t;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [rv_decode_pkg::INST_W-1:0]   inst,
    input  logic                               inst_valid,
    output rv_decode_pkg::dec_word_t           dec,
    output logic                               dec_valid
);
    import rv_decode_pkg::*;

    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    dec_word_t             dec_d;
    logic                  bad;

    assign opcode = inst[OPCODE_W-1:0];
    assign funct3 = inst[FUNCT3_LSB +: FUNCT3_W];
    assign funct7 = inst[FUNCT7_LSB +: FUNCT7_W];
    assign rd     = inst[RD_LSB +: REG_ADDR_W];
    assign rs1    = inst[RS1_LSB +: REG_ADDR_W];
    assign rs2    = inst[RS2_LSB +: REG_ADDR_W];

    always_comb begin
        bad            = 1'b0;
        dec_d          = '0;
        dec_d.inst     = inst;
        dec_d.alu_op   = ALU_ADD;
        dec_d.alu_src  = SRC_REG;
        dec_d.imm_kind = IMM_NONE;
        dec_d.mem_size = MEM_NONE;
        case (opcode)
            OP_REG: begin
                dec_d.reg_wen = 1'b1;
                dec_d.rs1     = rs1;
                dec_d.rs2     = rs2;
                dec_d.rd      = rd;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_d.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_d.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec_d.alu_op = ALU_AND;
                    {7'b0000001, 3'b111}: dec_d.alu_op = ALU_REMU;
                    {7'b0000000, 3'b110}: dec_d.alu_op = ALU_OR;
                    {7'b0000000, 3'b010}: dec_d.alu_op = ALU_SLT;
                    {7'b0000000, 3'b011}: dec_d.alu_op = ALU_SLTU;
                    default:              bad = 1'b1;
                endcase
            end
            OP_REG_W: begin
                dec_d.reg_wen = 1'b1;
                dec_d.word_op = 1'b1;
                dec_d.rs1     = rs1;
                dec_d.rs2     = rs2;
                dec_d.rd      = rd;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_d.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_d.alu_op = ALU_SUB;
                    {7'b0000001, 3'b000}: dec_d.alu_op = ALU_MUL;
                    {7'b0000000, 3'b001}: dec_d.alu_op = ALU_SLL;
                    {7'b0000001, 3'b100}: dec_d.alu_op = ALU_DIV;
                    {7'b0000001, 3'b110}: dec_d.alu_op = ALU_REM;
                    default:              bad = 1'b1;
                endcase
            end
            OP_IMM: begin
                dec_d.reg_wen  = 1'b1;
                dec_d.rs1      = rs1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_IMM;
                dec_d.imm_kind = IMM_I;
                case (funct3)
                    3'b000: dec_d.alu_op = ALU_ADD;
                    3'b111: dec_d.alu_op = ALU_AND;
                    3'b100: dec_d.alu_op = ALU_XOR;
                    3'b011: dec_d.alu_op = ALU_SLTU;
                    3'b001: begin
                        dec_d.alu_op   = ALU_SLL;
                        dec_d.imm_kind = IMM_SHAMT;
                        bad            = (funct7[6:1] != 6'b000000);  // 6-bit shamt on rv64
                    end
                    3'b101: begin
                        dec_d.alu_op   = ALU_SRA;
                        dec_d.imm_kind = IMM_SHAMT;
                        bad            = (funct7[6:1] != 6'b010000);  // only srai
                    end
                    default: bad = 1'b1;
                endcase
            end
            OP_IMM_W: begin
                dec_d.reg_wen  = 1'b1;
                dec_d.word_op  = 1'b1;
                dec_d.rs1      = rs1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_IMM;
                dec_d.imm_kind = IMM_I;
                bad            = (funct3 != 3'b000);  // addiw
            end
            OP_LOAD: begin
                dec_d.reg_wen  = 1'b1;
                dec_d.rs1      = rs1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_IMM;
                dec_d.imm_kind = IMM_I;
                case (funct3)
                    3'b001: dec_d.mem_size = MEM_HALF;
                    3'b010: dec_d.mem_size = MEM_WORD;
                    3'b011: dec_d.mem_size = MEM_DWORD;
                    3'b100: begin
                        dec_d.mem_size     = MEM_BYTE;
                        dec_d.mem_unsigned = 1'b1;
                    end
                    3'b101: begin
                        dec_d.mem_size     = MEM_HALF;
                        dec_d.mem_unsigned = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            OP_STORE: begin
                dec_d.store    = 1'b1;  // no rd write
                dec_d.rs1      = rs1;
                dec_d.rs2      = rs2;
                dec_d.alu_src  = SRC_IMM;
                dec_d.imm_kind = IMM_S;
                case (funct3)
                    3'b000:  dec_d.mem_size = MEM_BYTE;
                    3'b001:  dec_d.mem_size = MEM_HALF;
                    3'b010:  dec_d.mem_size = MEM_WORD;
                    3'b011:  dec_d.mem_size = MEM_DWORD;
                    default: bad = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                dec_d.branch   = 1'b1;
                dec_d.rs1      = rs1;
                dec_d.rs2      = rs2;
                dec_d.imm_kind = IMM_B;
                case (funct3)
                    3'b000:  dec_d.alu_op = ALU_EQ;
                    3'b001:  dec_d.alu_op = ALU_NE;
                    3'b100:  dec_d.alu_op = ALU_LT;
                    3'b101:  dec_d.alu_op = ALU_GE;
                    3'b110:  dec_d.alu_op = ALU_LTU;
                    3'b111:  dec_d.alu_op = ALU_GEU;
                    default: bad = 1'b1;
                endcase
            end
            OP_JAL: begin
                dec_d.jump     = 1'b1;
                dec_d.reg_wen  = 1'b1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_PC_PLUS4;
                dec_d.imm_kind = IMM_J;
            end
            OP_JALR: begin
                dec_d.jump     = 1'b1;
                dec_d.jalr     = 1'b1;
                dec_d.reg_wen  = 1'b1;
                dec_d.rs1      = rs1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_PC_PLUS4;
                dec_d.imm_kind = IMM_I;
                bad            = (funct3 != 3'b000);
            end
            OP_LUI: begin
                dec_d.reg_wen  = 1'b1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_IMM;  // x0 + imm
                dec_d.imm_kind = IMM_U;
            end
            OP_AUIPC: begin
                dec_d.reg_wen  = 1'b1;
                dec_d.rd       = rd;
                dec_d.alu_src  = SRC_IMM_PC;
                dec_d.imm_kind = IMM_U;
            end
            default: begin
                if (inst == EBREAK_INST) begin
                    dec_d.ebreak = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
        endcase
        // unknown encodings carry only the raw word and the flag
        if (bad) begin
            dec_d         = '0;
            dec_d.inst    = inst;
            dec_d.illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec <= dec_d;
        end
    end

endmodule

// File: hw/ctrl_fifo.sv
`timescale 1ns/1ns

module ctrl_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     not_empty,
    output logic     full,
    output logic     overflow
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign do_wr     = wr_en && !full;  // write into a full buffer is lost
    assign do_rd     = rd_en && not_empty;
    assign rd_data   = mem[rd_ptr];     // show-ahead head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;  // sticky
            end
        end
    end

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  rv_decode_pkg::dec_word_t   head,
    input  logic                       head_valid,
    input  logic                       stall,
    output logic                       pop,
    output rv_decode_pkg::exec_ctrl_t  ctrl,
    output logic                       out_valid
);
    import rv_decode_pkg::*;

    logic [INST_W-1:0] iw;
    logic [XLEN-1:0]   imm;
    logic [7:0]        wmask;
    exec_ctrl_t        nxt;

    assign iw  = head.inst;
    assign pop = head_valid && (!out_valid || !stall);  // output slot free

    always_comb begin
        case (head.imm_kind)
            IMM_I:     imm = {{(XLEN-12){iw[31]}}, iw[31:20]};
            IMM_SHAMT: imm = {{(XLEN-6){1'b0}}, iw[25:20]};
            IMM_S:     imm = {{(XLEN-12){iw[31]}}, iw[31:25], iw[11:7]};
            IMM_B:     imm = {{(XLEN-13){iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            IMM_U:     imm = {{(XLEN-32){iw[31]}}, iw[31:12], 12'b0};
            IMM_J:     imm = {{(XLEN-21){iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    always_comb begin
        wmask = 8'h00;
        if (head.store) begin
            case (head.mem_size)
                MEM_BYTE:  wmask = 8'h01;
                MEM_HALF:  wmask = 8'h03;
                MEM_WORD:  wmask = 8'h0F;
                MEM_DWORD: wmask = 8'hFF;
                default:   wmask = 8'h00;
            endcase
        end
    end

    always_comb begin
        nxt.rs1          = head.rs1;
        nxt.rs2          = head.rs2;
        nxt.rd           = head.rd;
        nxt.reg_wen      = head.reg_wen;
        nxt.branch       = head.branch;
        nxt.jump         = head.jump;
        nxt.jalr         = head.jalr;
        nxt.alu_op       = head.alu_op;
        nxt.alu_src      = head.alu_src;
        nxt.word_op      = head.word_op;
        nxt.mem_size     = head.mem_size;
        nxt.mem_unsigned = head.mem_unsigned;
        nxt.store        = head.store;
        nxt.illegal      = head.illegal;
        nxt.ebreak       = head.ebreak;
        nxt.imm          = imm;
        nxt.wmask        = wmask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!out_valid || !stall) begin
            out_valid <= head_valid;  // holds while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ctrl <= nxt;
        end
    end

endmodule

// File: hw/decode_top.sv
`timescale 1ns/1ns

module decode_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [rv_decode_pkg::INST_W-1:0]   inst,
    input  logic                               inst_valid,
    input  logic                               stall,
    output rv_decode_pkg::exec_ctrl_t          ctrl,
    output logic                               out_valid,
    output logic                               full,
    output logic                               overflow
);
    import rv_decode_pkg::*;

    dec_word_t dec_word;
    dec_word_t fifo_head;
    logic      dec_valid;
    logic      fifo_not_empty;
    logic      fifo_pop;

    inst_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec_word),
        .dec_valid  (dec_valid)
    );

    // absorbs execute stalls, drops and flags writes past full
    ctrl_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (dec_word_t)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (dec_valid),
        .wr_data   (dec_word),
        .rd_en     (fifo_pop),
        .rd_data   (fifo_head),
        .not_empty (fifo_not_empty),
        .full      (full),
        .overflow  (overflow)
    );

    issue_stage u_issue (
        .clk        (clk),
        .rst        (rst),
        .head       (fifo_head),
        .head_valid (fifo_not_empty),
        .stall      (stall),
        .pop        (fifo_pop),
        .ctrl       (ctrl),
        .out_valid  (out_valid)
    );

endmodule

// File: bench/tb_decode_tasks.svh
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);  // fold high bits down
endfunction

function automatic logic [31:0] encode_fields(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] op);
    return {f7, 10'd0, f3, 5'd0, op};
endfunction

// random bits everywhere outside the kept fields
function automatic logic [31:0] rand_inst(input logic [31:0] skel, input logic [31:0] keep);
    return (lcg_next() & ~keep) | (skel & keep);
endfunction

function automatic mem_size_e mem_size_of(input logic [1:0] sz);
    case (sz)
        2'd0:    return MEM_BYTE;
        2'd1:    return MEM_HALF;
        2'd2:    return MEM_WORD;
        default: return MEM_DWORD;
    endcase
endfunction

// expected issue output for a legal word with the caller's alu_op
function automatic exec_ctrl_t expected_ctrl(input logic [31:0] w, input alu_op_e op_sel);
    exec_ctrl_t e;
    logic [6:0] op;
    logic [2:0] f3;
    op = w[6:0];
    f3 = w[14:12];
    e = '0;
    e.alu_op = op_sel;
    e.alu_src = SRC_REG;
    e.mem_size = MEM_NONE;
    case (op)
        OP_REG, OP_REG_W: e.word_op = (op == OP_REG_W);
        OP_IMM, OP_IMM_W: begin
            e.word_op = (op == OP_IMM_W);
            e.alu_src = SRC_IMM;
            if (op == OP_IMM && f3[1:0] == 2'b01) begin
                e.imm = 64'(w[25:20]);  // zero-extended shamt
            end else begin
                e.imm = 64'($signed(w[31:20]));
            end
        end
        OP_LOAD: begin
            e.alu_src = SRC_IMM;
            e.imm = 64'($signed(w[31:20]));
            e.mem_size = mem_size_of(f3[1:0]);
            e.mem_unsigned = f3[2];
        end
        OP_STORE: begin
            e.store = 1'b1;
            e.alu_src = SRC_IMM;
            e.imm = 64'($signed({w[31:25], w[11:7]}));
            e.mem_size = mem_size_of(f3[1:0]);
            e.wmask = 8'((1 << (1 << f3[1:0])) - 1);  // one bit per byte
        end
        OP_BRANCH: begin
            e.branch = 1'b1;
            e.imm = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        end
        OP_JAL: begin
            e.jump = 1'b1;
            e.alu_src = SRC_PC_PLUS4;
            e.imm = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        end
        OP_JALR: begin
            e.jump = 1'b1;
            e.jalr = 1'b1;
            e.alu_src = SRC_PC_PLUS4;
            e.imm = 64'($signed(w[31:20]));
        end
        default: begin  // lui, auipc
            e.alu_src = (op == OP_LUI) ? SRC_IMM : SRC_IMM_PC;
            e.imm = 64'($signed({w[31:12], 12'b0}));
        end
    endcase
    e.reg_wen = !(e.store || e.branch);
    e.rd = e.reg_wen ? w[11:7] : '0;
    e.rs1 = (op == OP_JAL || op == OP_LUI || op == OP_AUIPC) ? '0 : w[19:15];
    e.rs2 = (e.store || e.branch || op == OP_REG || op == OP_REG_W) ? w[24:20] : '0;
    return e;
endfunction

task automatic compare_ctrl(input string name, input exec_ctrl_t exp, input exec_ctrl_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
endtask

// one strobe, then wait for the word at the output
task automatic drive_and_check(input string name, input logic [31:0] w, input exec_ctrl_t exp);
    int waited;
    @(posedge clk);
    inst <= w;
    inst_valid <= 1'b1;
    @(posedge clk);
    inst_valid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!out_valid && waited < OUT_WAIT) begin
        @(negedge clk);
        waited++;
    end
    if (!out_valid) begin
        errors++;
        $display("%s: out_valid did not rise within %0d cycles", name, OUT_WAIT);
    end else begin
        compare_ctrl(name, exp, ctrl);
    end
endtask

task automatic check_random_inst(input string name, input logic [31:0] skel,
                                 input logic [31:0] keep, input alu_op_e op_sel);
    logic [31:0] w;
    w = rand_inst(skel, keep);
    drive_and_check(name, w, expected_ctrl(w, op_sel));
endtask

task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, errors - start_errors);
    end
endtask

// File: bench/tb_decode_top.sv
`timescale 1ns/1ns

module tb_decode_top;
    import rv_decode_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int OUT_WAIT       = 8;
    localparam logic [31:0] LCG_SEED = 32'd85;
    localparam logic [31:0] KEEP_R   = 32'hFE00_707F;  // funct7, funct3, opcode
    localparam logic [31:0] KEEP_SH  = 32'hFC00_707F;  // shamt bit 5 stays random
    localparam logic [31:0] KEEP_I   = 32'h0000_707F;
    localparam logic [31:0] KEEP_OP  = 32'h0000_007F;

    logic              clk;
    logic              rst;
    logic [INST_W-1:0] inst;
    logic              inst_valid;
    logic              stall;
    exec_ctrl_t        ctrl;
    logic              out_valid;
    logic              full;
    logic              overflow;
    logic [31:0]       lcg_state;
    int                cycle_count = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;

    `include "tb_decode_tasks.svh"

    decode_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall),
        .ctrl       (ctrl),
        .out_valid  (out_valid),
        .full       (full),
        .overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic reset_latency();
        int start;
        start = errors;
        @(negedge clk);
        compare_flag("reset out_valid", 1'b0, out_valid);
        compare_flag("reset full", 1'b0, full);
        compare_flag("reset overflow", 1'b0, overflow);
        @(posedge clk);
        inst <= rand_inst(encode_fields(7'h00, 3'd0, OP_IMM), KEEP_I);
        inst_valid <= 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        compare_flag("latency cycle 1", 1'b0, out_valid);
        @(negedge clk);
        compare_flag("latency cycle 2", 1'b0, out_valid);
        @(negedge clk);
        compare_flag("latency cycle 3", 1'b1, out_valid);
        report_test("reset and latency", start);
    endtask

    task automatic reg_alu_ops();
        int start;
        start = errors;
        check_random_inst("add", encode_fields(7'h00, 3'd0, OP_REG), KEEP_R, ALU_ADD);
        check_random_inst("sub", encode_fields(7'h20, 3'd0, OP_REG), KEEP_R, ALU_SUB);
        check_random_inst("and", encode_fields(7'h00, 3'd7, OP_REG), KEEP_R, ALU_AND);
        check_random_inst("or", encode_fields(7'h00, 3'd6, OP_REG), KEEP_R, ALU_OR);
        check_random_inst("slt", encode_fields(7'h00, 3'd2, OP_REG), KEEP_R, ALU_SLT);
        check_random_inst("sltu", encode_fields(7'h00, 3'd3, OP_REG), KEEP_R, ALU_SLTU);
        check_random_inst("remu", encode_fields(7'h01, 3'd7, OP_REG), KEEP_R, ALU_REMU);
        check_random_inst("addw", encode_fields(7'h00, 3'd0, OP_REG_W), KEEP_R, ALU_ADD);
        check_random_inst("subw", encode_fields(7'h20, 3'd0, OP_REG_W), KEEP_R, ALU_SUB);
        check_random_inst("mulw", encode_fields(7'h01, 3'd0, OP_REG_W), KEEP_R, ALU_MUL);
        check_random_inst("sllw", encode_fields(7'h00, 3'd1, OP_REG_W), KEEP_R, ALU_SLL);
        check_random_inst("divw", encode_fields(7'h01, 3'd4, OP_REG_W), KEEP_R, ALU_DIV);
        check_random_inst("remw", encode_fields(7'h01, 3'd6, OP_REG_W), KEEP_R, ALU_REM);
        report_test("r-type and w-type", start);
    endtask

    task automatic imm_and_memory();
        int start;
        start = errors;
        check_random_inst("addi", encode_fields(7'h00, 3'd0, OP_IMM), KEEP_I, ALU_ADD);
        check_random_inst("andi", encode_fields(7'h00, 3'd7, OP_IMM), KEEP_I, ALU_AND);
        check_random_inst("xori", encode_fields(7'h00, 3'd4, OP_IMM), KEEP_I, ALU_XOR);
        check_random_inst("sltiu", encode_fields(7'h00, 3'd3, OP_IMM), KEEP_I, ALU_SLTU);
        check_random_inst("slli", encode_fields(7'h00, 3'd1, OP_IMM), KEEP_SH, ALU_SLL);
        check_random_inst("srai", encode_fields(7'h20, 3'd5, OP_IMM), KEEP_SH, ALU_SRA);
        check_random_inst("addiw", encode_fields(7'h00, 3'd0, OP_IMM_W), KEEP_I, ALU_ADD);
        check_random_inst("lw", encode_fields(7'h00, 3'd2, OP_LOAD), KEEP_I, ALU_ADD);
        check_random_inst("ld", encode_fields(7'h00, 3'd3, OP_LOAD), KEEP_I, ALU_ADD);
        check_random_inst("lbu", encode_fields(7'h00, 3'd4, OP_LOAD), KEEP_I, ALU_ADD);
        check_random_inst("lh", encode_fields(7'h00, 3'd1, OP_LOAD), KEEP_I, ALU_ADD);
        check_random_inst("lhu", encode_fields(7'h00, 3'd5, OP_LOAD), KEEP_I, ALU_ADD);
        check_random_inst("sb", encode_fields(7'h00, 3'd0, OP_STORE), KEEP_I, ALU_ADD);
        check_random_inst("sh", encode_fields(7'h00, 3'd1, OP_STORE), KEEP_I, ALU_ADD);
        check_random_inst("sw", encode_fields(7'h00, 3'd2, OP_STORE), KEEP_I, ALU_ADD);
        check_random_inst("sd", encode_fields(7'h00, 3'd3, OP_STORE), KEEP_I, ALU_ADD);
        report_test("immediates and memory", start);
    endtask

    task automatic control_flow();
        int start;
        start = errors;
        check_random_inst("beq", encode_fields(7'h00, 3'd0, OP_BRANCH), KEEP_I, ALU_EQ);
        check_random_inst("bne", encode_fields(7'h00, 3'd1, OP_BRANCH), KEEP_I, ALU_NE);
        check_random_inst("blt", encode_fields(7'h00, 3'd4, OP_BRANCH), KEEP_I, ALU_LT);
        check_random_inst("bge", encode_fields(7'h00, 3'd5, OP_BRANCH), KEEP_I, ALU_GE);
        check_random_inst("bltu", encode_fields(7'h00, 3'd6, OP_BRANCH), KEEP_I, ALU_LTU);
        check_random_inst("bgeu", encode_fields(7'h00, 3'd7, OP_BRANCH), KEEP_I, ALU_GEU);
        check_random_inst("jal", encode_fields(7'h00, 3'd0, OP_JAL), KEEP_OP, ALU_ADD);
        check_random_inst("jalr", encode_fields(7'h00, 3'd0, OP_JALR), KEEP_I, ALU_ADD);
        check_random_inst("lui", encode_fields(7'h00, 3'd0, OP_LUI), KEEP_OP, ALU_ADD);
        check_random_inst("auipc", encode_fields(7'h00, 3'd0, OP_AUIPC), KEEP_OP, ALU_ADD);
        report_test("branches and jumps", start);
    endtask

    task automatic illegal_words();
        exec_ctrl_t exp;
        int start;
        start = errors;
        exp = '0;
        exp.illegal = 1'b1;
        drive_and_check("bad funct7 w-type",
                        rand_inst(encode_fields(7'h7F, 3'd0, OP_REG_W), KEEP_R), exp);
        drive_and_check("unknown opcode",
                        rand_inst(encode_fields(7'h00, 3'd0, 7'h7F), KEEP_OP), exp);
        exp = '0;
        exp.ebreak = 1'b1;
        drive_and_check("ebreak", EBREAK_INST, exp);
        report_test("illegal and ebreak", start);
    endtask

    task automatic backpressure();
        exec_ctrl_t  exp_words [FIFO_DEPTH + 1];
        logic [31:0] w;
        int          start;
        int          waited;
        start = errors;
        // one word lands in the output register, the rest fill the FIFO, the last is dropped
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            w = rand_inst(encode_fields(7'h00, 3'd0, OP_IMM), KEEP_I);
            if (i < FIFO_DEPTH + 1) begin
                exp_words[i] = expected_ctrl(w, ALU_ADD);
            end
            @(posedge clk);
            stall <= 1'b1;
            inst <= w;
            inst_valid <= 1'b1;
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!overflow && waited < OUT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        compare_flag("burst full", 1'b1, full);
        compare_flag("burst overflow", 1'b1, overflow);
        compare_flag("stalled out_valid", 1'b1, out_valid);
        @(posedge clk);
        stall <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            @(negedge clk);
            compare_flag($sformatf("drain valid %0d", i), 1'b1, out_valid);
            compare_ctrl($sformatf("drain word %0d", i), exp_words[i], ctrl);
        end
        @(negedge clk);
        compare_flag("no word after drain", 1'b0, out_valid);
        report_test("back-pressure", start);
    endtask

    initial begin
        rst = 1'b1;
        inst = '0;
        inst_valid = 1'b0;
        stall = 1'b0;
        lcg_state = LCG_SEED;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_latency();
        reg_alu_ops();
        imm_and_memory();
        control_flow();
        illegal_words();
        backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+bench
hw/rv_decode_pkg.sv
hw/inst_decoder.sv
hw/ctrl_fifo.sv
hw/issue_stage.sv
hw/decode_top.sv
bench/tb_decode_top.sv
